/* rtl/controlPkg.sv */
package controlPkg;

  localparam int STEP_W = 4;

  // Last step of each fixed-length phase or EXEC sequence
  localparam logic [STEP_W-1:0] EXEC_LINK_LAST = 4'd1;
  localparam logic [STEP_W-1:0] EXEC_BRANCH_TEST = 4'd2;  // branchTaken sampled here
  localparam logic [STEP_W-1:0] EXEC_MULDIV_WAIT = 4'd3;  // Holds until done
  localparam logic [STEP_W-1:0] EXEC_ALU_LAST = 4'd4;
  localparam logic [STEP_W-1:0] EXEC_MULDIV_LAST = 4'd5;
  localparam logic [STEP_W-1:0] EXEC_MEM_LAST = 4'd8;
  localparam logic [STEP_W-1:0] MEMWAIT_LAST = 4'd1;
  localparam logic [STEP_W-1:0] EXCEPT_LAST = 4'd4;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_BLE   = 6'h06,
    OP_BGT   = 6'h07,
    OP_ADDI  = 6'h08,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_LB    = 6'h20,
    OP_LH    = 6'h21,
    OP_LW    = 6'h23,
    OP_SB    = 6'h28,
    OP_SH    = 6'h29,
    OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_MULT = 6'h18,
    FN_DIV  = 6'h1a,
    FN_ADD  = 6'h20,
    FN_SUB  = 6'h22,
    FN_AND  = 6'h24,
    FN_SLT  = 6'h2a
  } funct_e;

  // Codes shared with the datapath ALU control; 4..9 belong to dropped ops
  typedef enum logic [3:0] {
    ALU_PASSA = 4'd0,
    ALU_ADD   = 4'd1,
    ALU_SUB   = 4'd2,
    ALU_AND   = 4'd3,
    ALU_SLT   = 4'd10,
    ALU_BEQ   = 4'd11,
    ALU_BNE   = 4'd12,
    ALU_BLE   = 4'd13,
    ALU_BGT   = 4'd14
  } aluOp_e;

  typedef enum logic [3:0] {
    CLS_ALUREG, CLS_ALUIMM, CLS_BRANCH, CLS_JUMP, CLS_JUMPLINK, CLS_JUMPREG,
    CLS_LOAD, CLS_STORE, CLS_MUL, CLS_DIV, CLS_ILLEGAL
  } instrClass_e;

  typedef enum logic [2:0] {PH_FETCH, PH_EXEC, PH_MEMWAIT, PH_EXCEPT} phase_e;

  // Also the vector select, so the order matches the handler table
  typedef enum logic [1:0] {EXC_NONE, EXC_OPCODE, EXC_OVERFLOW, EXC_DIVZERO} excCause_e;

  typedef enum logic [1:0] {SIZE_NONE, SIZE_BYTE, SIZE_HALF, SIZE_WORD} accessSize_e;

  typedef struct packed {
    instrClass_e instrClass;
    aluOp_e aluOp;
    accessSize_e accessSize;
    logic isAddiu;
  } decodedInstr_t;

  typedef struct packed {
    logic pc;
    logic epc;
    logic mem;
    logic ir;
    logic aluOut;
    logic regFile;
    logic a;
    logic b;
    logic hi;
    logic lo;
    logic memData;
  } regWrites_t;

  typedef struct packed {
    logic [1:0] aluSrcA;  // 0 PC, 1 A
    logic [1:0] aluSrcB;  // 0 B, 1 four, 2 imm, 3 imm << 2
    logic [2:0] pcSrc;    // 0 ALU, 1 aluOut, 2 jump target, 4 vector
    logic [1:0] regDst;   // 0 rt, 1 rd, 3 ra
    logic [2:0] regData;  // 0 ALU, 2 load data, 6 return address
    logic [1:0] memAddr;  // 0 PC, 1 aluOut, 3 vector table
    excCause_e excVec;
  } muxSelects_t;

  typedef struct packed {
    aluOp_e aluOp;
    logic mulStart;
    logic mulReset;
    logic divStart;
    logic divReset;
    accessSize_e loadSize;
    accessSize_e storeSize;
  } unitCtrl_t;

endpackage

/* rtl/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
  input controlPkg::opcode_e opcode,
  input controlPkg::funct_e funct,
  output controlPkg::decodedInstr_t decoded
);
  import controlPkg::*;

  always_comb begin
    decoded.instrClass = CLS_ILLEGAL;  // Anything not matched below
    decoded.aluOp = ALU_PASSA;
    decoded.accessSize = SIZE_NONE;
    decoded.isAddiu = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_ADD: begin
            decoded.instrClass = CLS_ALUREG;
            decoded.aluOp = ALU_ADD;
          end
          FN_SUB: begin
            decoded.instrClass = CLS_ALUREG;
            decoded.aluOp = ALU_SUB;
          end
          FN_AND: begin
            decoded.instrClass = CLS_ALUREG;
            decoded.aluOp = ALU_AND;
          end
          FN_SLT: begin
            decoded.instrClass = CLS_ALUREG;
            decoded.aluOp = ALU_SLT;
          end
          FN_JR: decoded.instrClass = CLS_JUMPREG;  // A passes straight through
          FN_MULT: decoded.instrClass = CLS_MUL;
          FN_DIV: decoded.instrClass = CLS_DIV;
          default: decoded.instrClass = CLS_ILLEGAL;
        endcase
      end
      OP_ADDI, OP_ADDIU: begin
        decoded.instrClass = CLS_ALUIMM;
        decoded.aluOp = ALU_ADD;
        decoded.isAddiu = (opcode == OP_ADDIU);  // No overflow trap
      end
      OP_SLTI: begin
        decoded.instrClass = CLS_ALUIMM;
        decoded.aluOp = ALU_SLT;
      end
      OP_BEQ, OP_BNE, OP_BLE, OP_BGT: begin
        decoded.instrClass = CLS_BRANCH;
        case (opcode)
          OP_BEQ: decoded.aluOp = ALU_BEQ;
          OP_BNE: decoded.aluOp = ALU_BNE;
          OP_BLE: decoded.aluOp = ALU_BLE;
          default: decoded.aluOp = ALU_BGT;
        endcase
      end
      OP_J: decoded.instrClass = CLS_JUMP;
      OP_JAL: decoded.instrClass = CLS_JUMPLINK;
      OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB: begin
        // Address is always base plus offset
        decoded.aluOp = ALU_ADD;
        if (opcode inside {OP_LW, OP_LH, OP_LB}) decoded.instrClass = CLS_LOAD;
        else decoded.instrClass = CLS_STORE;
        if (opcode inside {OP_LW, OP_SW}) decoded.accessSize = SIZE_WORD;
        else if (opcode inside {OP_LH, OP_SH}) decoded.accessSize = SIZE_HALF;
        else decoded.accessSize = SIZE_BYTE;
      end
      default: decoded.instrClass = CLS_ILLEGAL;
    endcase
  end

endmodule

/* rtl/exceptionTracker.sv */
`timescale 1ns/10ps

module exceptionTracker (
  input logic clk,
  input logic reset_in,
  input logic [1:0] excFlags,  // [1] overflow, [0] divide by zero
  input controlPkg::decodedInstr_t decoded,
  input controlPkg::phase_e phase,
  input logic [controlPkg::STEP_W-1:0] step,
  output logic excPending,
  output controlPkg::excCause_e cause
);
  import controlPkg::*;

  logic ovfPending;
  logic divZeroPending;
  logic opcodePending;
  logic addiuRunning;
  logic exceptDone;

  assign addiuRunning = (phase == PH_EXEC) && decoded.isAddiu;
  assign exceptDone = (phase == PH_EXCEPT) && (step == EXCEPT_LAST);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      ovfPending <= 1'b0;
      divZeroPending <= 1'b0;
      opcodePending <= 1'b0;
    end else if (exceptDone) begin
      ovfPending <= 1'b0;
      divZeroPending <= 1'b0;
      opcodePending <= 1'b0;
    end else begin
      if (excFlags[1] && !addiuRunning) ovfPending <= 1'b1;
      if (excFlags[0]) divZeroPending <= 1'b1;
      // Follows the decoder through fetch, so the decode step has the last word
      if (phase == PH_FETCH && step != '0) begin
        opcodePending <= (decoded.instrClass == CLS_ILLEGAL);
      end
    end
  end

  always_comb begin
    if (opcodePending) cause = EXC_OPCODE;  // Highest priority
    else if (ovfPending) cause = EXC_OVERFLOW;
    else if (divZeroPending) cause = EXC_DIVZERO;
    else cause = EXC_NONE;
  end

  assign excPending = opcodePending | ovfPending | divZeroPending;

  causeKnown: assert property (@(posedge clk) disable iff (reset_in)
    excPending |-> cause != EXC_NONE);

endmodule

/* rtl/phaseSequencer.sv */
`timescale 1ns/10ps

module phaseSequencer #(
  parameter int memReadLatency = 2
) (
  input logic clk,
  input logic reset_in,
  input controlPkg::decodedInstr_t decoded,
  input logic excPending,
  input logic branchTaken,
  input logic mulDone,
  input logic divDone,
  output controlPkg::phase_e phase,
  output logic [controlPkg::STEP_W-1:0] step
);
  import controlPkg::*;

  // Decode happens in the last fetch step, two cycles after the IR load
  localparam logic [STEP_W-1:0] fetchLast = STEP_W'(memReadLatency + 2);
  localparam int maxStep = (memReadLatency + 2 > int'(EXEC_MEM_LAST)) ?
                           memReadLatency + 2 : int'(EXEC_MEM_LAST);

  phase_e nextPhase;
  logic [STEP_W-1:0] nextStep;
  logic execDone;
  logic execHold;

  // EXEC length per class, with the data-dependent exits
  always_comb begin
    execDone = 1'b0;
    execHold = 1'b0;
    case (decoded.instrClass)
      CLS_ALUREG, CLS_ALUIMM, CLS_JUMPREG: execDone = (step == EXEC_ALU_LAST);
      CLS_BRANCH: begin
        execDone = (step == EXEC_BRANCH_TEST && !branchTaken) || (step == EXEC_ALU_LAST);
      end
      CLS_JUMPLINK: execDone = (step == EXEC_LINK_LAST);
      CLS_LOAD, CLS_STORE: execDone = (step == EXEC_MEM_LAST);
      CLS_MUL: begin
        execHold = (step == EXEC_MULDIV_WAIT) && !mulDone;
        execDone = (step == EXEC_MULDIV_LAST);
      end
      CLS_DIV: begin
        execHold = (step == EXEC_MULDIV_WAIT) && !divDone;
        execDone = (step == EXEC_MULDIV_LAST);
      end
      default: execDone = 1'b1;
    endcase
  end

  always_comb begin
    nextPhase = phase;
    nextStep = step + 1'b1;
    case (phase)
      PH_FETCH: begin
        if (step == '0 && excPending) begin  // Trap before any PC+4
          nextPhase = PH_EXCEPT;
          nextStep = '0;
        end else if (step == fetchLast) begin
          nextStep = '0;
          case (decoded.instrClass)
            CLS_ILLEGAL: nextPhase = PH_EXCEPT;
            CLS_JUMP: nextPhase = PH_FETCH;  // Done with the decode-time PC write
            default: nextPhase = PH_EXEC;
          endcase
        end
      end
      PH_EXEC: begin
        if (execDone) begin
          nextStep = '0;
          if (decoded.instrClass inside {CLS_LOAD, CLS_STORE}) nextPhase = PH_MEMWAIT;
          else nextPhase = PH_FETCH;
        end else if (execHold) begin
          nextStep = step;
        end
      end
      PH_MEMWAIT: begin
        if (step == MEMWAIT_LAST) begin
          nextPhase = PH_FETCH;
          nextStep = '0;
        end
      end
      PH_EXCEPT: begin
        if (step == EXCEPT_LAST) begin
          nextPhase = PH_MEMWAIT;
          nextStep = '0;
        end
      end
      default: begin
        nextPhase = PH_FETCH;
        nextStep = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= PH_FETCH;
      step <= '0;
    end else begin
      phase <= nextPhase;
      step <= nextStep;
    end
  end

  stepInRange: assert property (@(posedge clk) disable iff (reset_in)
    int'(step) <= maxStep);

endmodule

/* rtl/controlWordGen.sv */
`timescale 1ns/10ps

module controlWordGen #(
  parameter int memReadLatency = 2
) (
  input logic clk,
  input logic reset_in,
  input controlPkg::phase_e phase,
  input logic [controlPkg::STEP_W-1:0] step,
  input controlPkg::decodedInstr_t decoded,
  input controlPkg::excCause_e cause,
  output controlPkg::regWrites_t writes,
  output controlPkg::muxSelects_t selects,
  output controlPkg::unitCtrl_t unitCtrl
);
  import controlPkg::*;

  localparam logic [STEP_W-1:0] irStep = STEP_W'(memReadLatency);
  localparam logic [STEP_W-1:0] fetchLast = STEP_W'(memReadLatency + 2);
  localparam unitCtrl_t unitIdle = '{
    aluOp: ALU_PASSA,
    mulStart: 1'b0,
    mulReset: 1'b1,
    divStart: 1'b0,
    divReset: 1'b1,
    loadSize: SIZE_NONE,
    storeSize: SIZE_NONE
  };

  decodedInstr_t instrReg;
  regWrites_t wrNext;
  muxSelects_t selNext;
  unitCtrl_t unitNext;
  logic fetchDecode;

  assign fetchDecode = (phase == PH_FETCH) && (step == fetchLast);

  always_ff @(posedge clk) begin
    if (fetchDecode) instrReg <= decoded;
  end

  always_comb begin
    wrNext = '0;
    selNext = '0;
    unitNext = unitIdle;
    case (phase)
      PH_FETCH: begin
        if (step == '0 && cause == EXC_NONE) begin  // PC+4 while memory reads at PC
          selNext.aluSrcB = 2'b01;
          unitNext.aluOp = ALU_ADD;
          wrNext.aluOut = 1'b1;
        end
        if (step == irStep) wrNext.ir = 1'b1;
        if (fetchDecode) begin
          wrNext.pc = 1'b1;
          selNext.pcSrc = 3'b001;
          if (decoded.instrClass inside {CLS_JUMP, CLS_JUMPLINK}) selNext.pcSrc = 3'b010;
          if (decoded.instrClass == CLS_JUMPLINK) begin
            wrNext.regFile = 1'b1;
            selNext.regDst = 2'b11;
            selNext.regData = 3'b110;
          end
        end
      end
      PH_EXEC: begin
        case (instrReg.instrClass)
          CLS_ALUREG, CLS_ALUIMM: begin
            if (step == '0) begin
              wrNext.a = 1'b1;
              wrNext.b = (instrReg.instrClass == CLS_ALUREG);
            end else begin
              selNext.aluSrcA = 2'b01;
              selNext.aluSrcB = (instrReg.instrClass == CLS_ALUREG) ? 2'b00 : 2'b10;
              unitNext.aluOp = instrReg.aluOp;
            end
            if (step == 4'd2) begin
              wrNext.regFile = 1'b1;
              selNext.regDst = (instrReg.instrClass == CLS_ALUREG) ? 2'b01 : 2'b00;
            end
          end
          CLS_JUMPREG: begin
            if (step == '0) wrNext.a = 1'b1;
            else selNext.aluSrcA = 2'b01;
            if (step == 4'd2) wrNext.pc = 1'b1;  // PC from the ALU pass of A
          end
          CLS_BRANCH: begin
            if (step == '0) begin
              wrNext.a = 1'b1;
              wrNext.b = 1'b1;
            end else if (step == 4'd1) begin  // Compare feeds branchTaken
              selNext.aluSrcA = 2'b01;
              unitNext.aluOp = instrReg.aluOp;
            end else begin  // Target is PC plus shifted offset
              selNext.aluSrcB = 2'b11;
              unitNext.aluOp = ALU_ADD;
            end
            if (step == 4'd3) wrNext.pc = 1'b1;
          end
          CLS_LOAD, CLS_STORE: begin
            if (step == '0) begin
              wrNext.a = 1'b1;
              wrNext.b = (instrReg.instrClass == CLS_STORE);
            end else if (step == 4'd1) begin
              selNext.aluSrcA = 2'b01;
              selNext.aluSrcB = 2'b10;
              unitNext.aluOp = ALU_ADD;
              wrNext.aluOut = 1'b1;
            end else begin
              selNext.memAddr = 2'b01;
            end
            if (step == 4'd4) wrNext.memData = 1'b1;  // Stores merge into this word
            if (step >= 4'd4) begin
              if (instrReg.instrClass == CLS_LOAD) unitNext.loadSize = instrReg.accessSize;
              else unitNext.storeSize = instrReg.accessSize;
            end
            if (step == 4'd6) begin
              if (instrReg.instrClass == CLS_LOAD) begin
                wrNext.regFile = 1'b1;
                selNext.regData = 3'b010;
              end else begin
                wrNext.mem = 1'b1;
              end
            end
          end
          CLS_MUL, CLS_DIV: begin
            if (step == '0) begin
              wrNext.a = 1'b1;
              wrNext.b = 1'b1;
            end else if (step < EXEC_MULDIV_LAST) begin
              if (instrReg.instrClass == CLS_MUL) begin
                unitNext.mulReset = 1'b0;
                unitNext.mulStart = (step <= EXEC_MULDIV_WAIT);
              end else begin
                unitNext.divReset = 1'b0;
                unitNext.divStart = (step <= EXEC_MULDIV_WAIT);
              end
            end
            if (step == EXEC_MULDIV_LAST - 1'b1) begin
              wrNext.hi = 1'b1;
              wrNext.lo = 1'b1;
            end
          end
          default: wrNext = '0;
        endcase
      end
      PH_EXCEPT: begin
        selNext.pcSrc = 3'b100;
        selNext.memAddr = 2'b11;
        selNext.excVec = cause;
        if (step == '0) begin  // PC-4 gives the faulting address for EPC
          selNext.aluSrcB = 2'b01;
          unitNext.aluOp = ALU_SUB;
          wrNext.aluOut = 1'b1;
        end
        if (step == 4'd2) begin
          wrNext.epc = 1'b1;
          wrNext.pc = 1'b1;
        end
      end
      default: selNext.memAddr = 2'b00;  // MEMWAIT keeps PC on the address bus
    endcase
  end

  // Outputs trail the phase and step that produced them by one cycle
  always_ff @(posedge clk) begin
    if (reset_in) begin
      writes <= '0;
      selects <= '0;
      unitCtrl <= unitIdle;
    end else begin
      writes <= wrNext;
      selects <= selNext;
      unitCtrl <= unitNext;
    end
  end

  pcIrApart: assert property (@(posedge clk) disable iff (reset_in)
    !(writes.pc && writes.ir));
  memRegApart: assert property (@(posedge clk) disable iff (reset_in)
    !(writes.mem && writes.regFile));
  epcInExcept: assert property (@(posedge clk) disable iff (reset_in)
    writes.epc |-> phase == PH_EXCEPT);

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit #(
  parameter int memReadLatency = 2
) (
  input logic clk,
  input logic reset_in,
  input controlPkg::opcode_e opcode,
  input controlPkg::funct_e funct,
  input logic branchTaken,
  input logic mulDone,
  input logic divDone,
  input logic [1:0] excFlags,
  output controlPkg::regWrites_t writes,
  output controlPkg::muxSelects_t selects,
  output controlPkg::unitCtrl_t unitCtrl
);
  import controlPkg::*;

  decodedInstr_t decoded;
  logic excPending;
  excCause_e cause;
  phase_e phase;
  logic [STEP_W-1:0] step;

  instrDecoder u_instrDecoder (
    .opcode(opcode),
    .funct(funct),
    .decoded(decoded)
  );

  exceptionTracker u_exceptionTracker (
    .clk(clk),
    .reset_in(reset_in),
    .excFlags(excFlags),
    .decoded(decoded),
    .phase(phase),
    .step(step),
    .excPending(excPending),
    .cause(cause)
  );

  phaseSequencer #(.memReadLatency(memReadLatency)) u_phaseSequencer (
    .clk(clk),
    .reset_in(reset_in),
    .decoded(decoded),
    .excPending(excPending),
    .branchTaken(branchTaken),
    .mulDone(mulDone),
    .divDone(divDone),
    .phase(phase),
    .step(step)
  );

  controlWordGen #(.memReadLatency(memReadLatency)) u_controlWordGen (
    .clk(clk),
    .reset_in(reset_in),
    .phase(phase),
    .step(step),
    .decoded(decoded),
    .cause(cause),
    .writes(writes),
    .selects(selects),
    .unitCtrl(unitCtrl)
  );

endmodule

/* testbench/tb_controlUnit.sv */
`timescale 1ns/10ps

module tb_controlUnit;
  import controlPkg::*;

  localparam int memReadLatency = 2;
  localparam int fetchCycles = memReadLatency + 3;
  localparam int maxDelay = 7;  // Longest random wait before a done input rises
  localparam int randomSeed = 32'hbde3;

  // One instruction and what its ir-to-ir window should contain
  typedef struct packed {
    opcode_e op;
    funct_e fn;
    logic taken;
    logic [1:0] inject;  // Flags pulsed in EXEC step 2
    int len;             // EXEC plus MEMWAIT, or the trap overhead
    int pcCount;
    int rfCount;
    int memCount;
    int mdCount;
    int hiLoCount;
    aluOp_e alu;
    accessSize_e size;
    excCause_e vec;
  } stimRow_t;

  typedef struct packed {
    int pc;
    int regFile;
    int mem;
    int memData;
    int hi;
    int lo;
    int epc;
    int mulStart;
    int divStart;
  } strobeCounts_t;

  logic clk;
  logic reset_in;
  opcode_e opcode;
  funct_e funct;
  logic branchTaken;
  logic mulDone;
  logic divDone;
  logic [1:0] excFlags;
  regWrites_t writes;
  muxSelects_t selects;
  unitCtrl_t unitCtrl;

  stimRow_t rows[$];
  strobeCounts_t counts;
  int cycleCount = 0;
  int cycleLimit = 0;

  controlUnit #(.memReadLatency(memReadLatency)) u_controlUnit (
    .clk(clk),
    .reset_in(reset_in),
    .opcode(opcode),
    .funct(funct),
    .branchTaken(branchTaken),
    .mulDone(mulDone),
    .divDone(divDone),
    .excFlags(excFlags),
    .writes(writes),
    .selects(selects),
    .unitCtrl(unitCtrl)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("timeout: no next ir strobe after %0d cycles", cycleCount);
      $display("TB FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic checkValue(input string name, input int got, input int expected);
    assert (got == expected) else begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
      $display("TB FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic addRow(input opcode_e op, input funct_e fn, input logic taken,
                        input logic [1:0] inject, input int len, input int pcCount,
                        input int rfCount, input int memCount, input int mdCount,
                        input int hiLoCount, input aluOp_e alu, input accessSize_e size,
                        input excCause_e vec);
    stimRow_t r;
    r = '{op, fn, taken, inject, len, pcCount, rfCount, memCount, mdCount, hiLoCount,
          alu, size, vec};
    rows.push_back(r);
  endtask

  task automatic buildTable();
    addRow(OP_RTYPE, FN_ADD, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_ADD, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, FN_SUB, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_SUB, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, FN_AND, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_AND, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, FN_SLT, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_SLT, SIZE_NONE, EXC_NONE);
    addRow(OP_ADDI, FN_ADD, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_ADD, SIZE_NONE, EXC_NONE);
    addRow(OP_ADDIU, FN_ADD, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_ADD, SIZE_NONE, EXC_NONE);
    addRow(OP_SLTI, FN_ADD, 1'b0, 2'b00, 5, 1, 1, 0, 0, 0, ALU_SLT, SIZE_NONE, EXC_NONE);
    // Taken branches add a second pc strobe
    addRow(OP_BEQ, FN_ADD, 1'b0, 2'b00, 3, 1, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_BEQ, FN_ADD, 1'b1, 2'b00, 5, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_BNE, FN_ADD, 1'b1, 2'b00, 5, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_BLE, FN_ADD, 1'b0, 2'b00, 3, 1, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_BGT, FN_ADD, 1'b1, 2'b00, 5, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_J, FN_ADD, 1'b0, 2'b00, 0, 1, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_JAL, FN_ADD, 1'b0, 2'b00, 2, 1, 1, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, FN_JR, 1'b0, 2'b00, 5, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_LW, FN_ADD, 1'b0, 2'b00, 11, 1, 1, 0, 1, 0, ALU_PASSA, SIZE_WORD, EXC_NONE);
    addRow(OP_LH, FN_ADD, 1'b0, 2'b00, 11, 1, 1, 0, 1, 0, ALU_PASSA, SIZE_HALF, EXC_NONE);
    addRow(OP_LB, FN_ADD, 1'b0, 2'b00, 11, 1, 1, 0, 1, 0, ALU_PASSA, SIZE_BYTE, EXC_NONE);
    addRow(OP_SW, FN_ADD, 1'b0, 2'b00, 11, 1, 0, 1, 1, 0, ALU_PASSA, SIZE_WORD, EXC_NONE);
    addRow(OP_SH, FN_ADD, 1'b0, 2'b00, 11, 1, 0, 1, 1, 0, ALU_PASSA, SIZE_HALF, EXC_NONE);
    addRow(OP_SB, FN_ADD, 1'b0, 2'b00, 11, 1, 0, 1, 1, 0, ALU_PASSA, SIZE_BYTE, EXC_NONE);
    addRow(OP_RTYPE, FN_MULT, 1'b0, 2'b00, 6, 1, 0, 0, 0, 1, ALU_PASSA, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, FN_DIV, 1'b0, 2'b00, 6, 1, 0, 0, 0, 1, ALU_PASSA, SIZE_NONE, EXC_NONE);
    // Trap rows: EXCEPT plus MEMWAIT, and for a flagged instruction one trapped fetch cycle
    addRow(opcode_e'(6'h3f), FN_ADD, 1'b0, 2'b00, 7, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE,
           EXC_OPCODE);
    addRow(OP_RTYPE, FN_ADD, 1'b0, 2'b10, 13, 2, 1, 0, 0, 0, ALU_ADD, SIZE_NONE, EXC_OVERFLOW);
    addRow(OP_RTYPE, FN_DIV, 1'b0, 2'b01, 14, 2, 0, 0, 0, 1, ALU_PASSA, SIZE_NONE,
           EXC_DIVZERO);
    addRow(OP_ADDIU, FN_ADD, 1'b0, 2'b10, 5, 1, 1, 0, 0, 0, ALU_ADD, SIZE_NONE, EXC_NONE);
    addRow(OP_RTYPE, funct_e'(6'h3f), 1'b0, 2'b00, 7, 2, 0, 0, 0, 0, ALU_PASSA, SIZE_NONE,
           EXC_OPCODE);
  endtask

  function automatic int limitFromTable();
    int total;
    total = memReadLatency + 4 + 50;  // Reset, first fetch and margin
    foreach (rows[i]) begin
      total += fetchCycles + rows[i].len;
      if (rows[i].hiLoCount != 0) total += maxDelay;
    end
    return total;
  endfunction

  task automatic sampleCycle(input stimRow_t r, input string tag);
    accessSize_e expLoad;
    accessSize_e expStore;
    expLoad = (r.memCount != 0) ? SIZE_NONE : r.size;
    expStore = (r.memCount != 0) ? r.size : SIZE_NONE;
    counts.pc += int'(writes.pc);
    counts.regFile += int'(writes.regFile);
    counts.mem += int'(writes.mem);
    counts.memData += int'(writes.memData);
    counts.hi += int'(writes.hi);
    counts.lo += int'(writes.lo);
    counts.epc += int'(writes.epc);
    counts.mulStart += int'(unitCtrl.mulStart);
    counts.divStart += int'(unitCtrl.divStart);
    if (writes.regFile) begin
      checkValue({tag, " unitCtrl.aluOp"}, int'(unitCtrl.aluOp), int'(r.alu));
    end
    if (writes.regFile || writes.mem || writes.memData) begin
      checkValue({tag, " unitCtrl.loadSize"}, int'(unitCtrl.loadSize), int'(expLoad));
      checkValue({tag, " unitCtrl.storeSize"}, int'(unitCtrl.storeSize), int'(expStore));
    end
    if (writes.epc) begin  // Trap entry writes EPC and the vector PC at once
      checkValue({tag, " selects.excVec"}, int'(selects.excVec), int'(r.vec));
      checkValue({tag, " writes.pc at epc"}, int'(writes.pc), 1);
    end
  endtask

  task automatic checkWindow(input stimRow_t r, input string tag, input int period,
                             input int delay);
    checkValue({tag, " ir period"}, period, fetchCycles + r.len + delay);
    checkValue({tag, " writes.pc count"}, counts.pc, r.pcCount);
    checkValue({tag, " writes.regFile count"}, counts.regFile, r.rfCount);
    checkValue({tag, " writes.mem count"}, counts.mem, r.memCount);
    checkValue({tag, " writes.memData count"}, counts.memData, r.mdCount);
    checkValue({tag, " writes.hi count"}, counts.hi, r.hiLoCount);
    checkValue({tag, " writes.lo count"}, counts.lo, r.hiLoCount);
    checkValue({tag, " writes.epc count"}, counts.epc, (r.vec != EXC_NONE) ? 1 : 0);
    checkValue({tag, " unitCtrl.mulStart seen"}, int'(counts.mulStart != 0),
               int'(r.hiLoCount != 0 && r.fn == FN_MULT));
    checkValue({tag, " unitCtrl.divStart seen"}, int'(counts.divStart != 0),
               int'(r.hiLoCount != 0 && r.fn == FN_DIV));
  endtask

  initial begin
    int seedValue;
    int delay;
    int period;
    int waitCount;
    int k;
    string tag;
    stimRow_t r;
    seedValue = $urandom(randomSeed);
    reset_in = 1'b1;
    opcode = OP_RTYPE;
    funct = FN_ADD;
    branchTaken = 1'b0;
    mulDone = 1'b0;
    divDone = 1'b0;
    excFlags = 2'b00;
    buildTable();
    cycleLimit = limitFromTable();

    @(posedge clk);
    @(negedge clk);
    checkValue("writes in reset", int'(writes), 0);
    checkValue("selects in reset", int'(selects), 0);
    checkValue("unitCtrl.mulReset in reset", int'(unitCtrl.mulReset), 1);
    checkValue("unitCtrl.divReset in reset", int'(unitCtrl.divReset), 1);
    @(posedge clk);
    reset_in <= 1'b0;

    // Outputs are registered, so ir shows one cycle after its step
    waitCount = 0;
    @(negedge clk);
    while (!writes.ir) begin
      @(posedge clk);
      waitCount++;
      @(negedge clk);
    end
    checkValue("cycles to first writes.ir", waitCount, memReadLatency + 1);

    foreach (rows[i]) begin
      r = rows[i];
      tag = $sformatf("row %0d", i);
      delay = (r.hiLoCount != 0) ? int'($urandom % (maxDelay + 1)) : 0;
      counts = '0;
      period = 1;
      sampleCycle(r, tag);  // The ir cycle opens the window
      @(posedge clk);
      opcode <= r.op;
      funct <= r.fn;
      branchTaken <= r.taken;
      mulDone <= 1'b0;
      divDone <= 1'b0;
      excFlags <= 2'b00;
      k = 0;
      @(negedge clk);
      while (!writes.ir) begin
        sampleCycle(r, tag);
        period++;
        @(posedge clk);
        k++;
        excFlags <= (k == 3) ? r.inject : 2'b00;  // Seen while in EXEC step 2
        if (r.hiLoCount != 0 && k == 4 + delay) begin  // Step 3 holds until this lands
          if (r.fn == FN_MULT) mulDone <= 1'b1;
          else divDone <= 1'b1;
        end
        @(negedge clk);
      end
      checkWindow(r, tag, period, delay);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

/* mipsControl.f */
rtl/controlPkg.sv
rtl/instrDecoder.sv
rtl/exceptionTracker.sv
rtl/phaseSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
testbench/tb_controlUnit.sv

/* run.sh */
#!/bin/sh
set -e

# Build the testbench with Verilator and run it
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f mipsControl.f \
  --top-module tb_controlUnit -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"
